/* rtl/snoop_pkg.sv */
package snoop_pkg;

  // --------------------
  // Basic widths
  // --------------------

  // Program counter as seen at the core trace port
  typedef logic [63:0] pc_t;

  // Trace fields and register data
  typedef logic [31:0] word_t;

  // Privilege level, encoded as in the core
  typedef logic [1:0] priv_t;

  // Control-transfer record type
  typedef logic [3:0] ctr_type_t;

  // Configuration register address
  typedef logic [1:0] cfg_addr_t;

  // Number of cores feeding the snooper
  localparam int unsigned NUM_CORES = 2;

  // --------------------
  // Trace records
  // --------------------

  // One branch record as presented by a core
  typedef struct packed {
    logic      pc_v;
    pc_t       src_pc;
    pc_t       dst_pc;
    ctr_type_t ctr_type;
    priv_t     priv;
    word_t     instr;
  } core_trace_t;

  // Packed record in the snooper trace layout
  typedef struct packed {
    priv_t priv_lvl;
    word_t pc_src_h;
    word_t pc_src_l;
    word_t pc_dst_h;
    word_t pc_dst_l;
    word_t metadata;
    word_t opcode;
  } trace_t;

  // Packing widths
  localparam int unsigned PC_HI_W    = 31;
  localparam int unsigned META_PAD_W = $bits(word_t) - $bits(ctr_type_t);

  // --------------------
  // Register map
  // --------------------

  localparam cfg_addr_t REG_CTRL      = 2'd0;
  localparam cfg_addr_t REG_WATERMARK = 2'd1;
  localparam cfg_addr_t REG_TRIGGER   = 2'd2;
  localparam cfg_addr_t REG_STATUS    = 2'd3;

  // Control register bits
  localparam int unsigned CTRL_CORE_SEL_BIT = 0;
  localparam int unsigned CTRL_TRIG_EN_BIT  = 1;

  // Status register layout, fill count in the low half
  localparam int unsigned STATUS_COUNT_W = 16;
  localparam int unsigned STATUS_OVF_BIT = 16;

endpackage

/* rtl/trace_capture.sv */
`timescale 1ns/100ps

module trace_capture (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  snoop_pkg::core_trace_t [snoop_pkg::NUM_CORES-1:0]    core_trace_i,
  input  logic                                                 core_sel_i,
  output snoop_pkg::trace_t                                    rec_o,
  output logic                                                 rec_push_o
);

  import snoop_pkg::*;

  // --------------------
  // Packing helpers
  // --------------------

  // High word keeps bits 62..32 behind a zero bit
  function automatic word_t pc_high(input pc_t pc);
    word_t w;
    w = {1'b0, pc[32+PC_HI_W-1:32]};
    return w;
  endfunction

  // Low word drops bit 0, which is always zero for aligned fetches
  function automatic word_t pc_low(input pc_t pc);
    word_t w;
    w = {pc[31:1], 1'b0};
    return w;
  endfunction

  function automatic trace_t pack_record(input core_trace_t ct);
    trace_t t;
    t.priv_lvl = ct.priv;
    t.pc_src_h = pc_high(ct.src_pc);
    t.pc_src_l = pc_low(ct.src_pc);
    t.pc_dst_h = pc_high(ct.dst_pc);
    t.pc_dst_l = pc_low(ct.dst_pc);
    t.metadata = {{META_PAD_W{1'b0}}, ct.ctr_type};
    t.opcode   = ct.instr;
    return t;
  endfunction

  // --------------------
  // Core select
  // --------------------

  core_trace_t sel_trace;
  trace_t      rec_d;
  trace_t      rec_q;
  logic        push_q;

  always_comb begin
    sel_trace = core_trace_i[core_sel_i];
    rec_d     = pack_record(sel_trace);
  end

  // Push flag follows the selected valid strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      push_q <= 1'b0;
    end else begin
      push_q <= sel_trace.pc_v;
    end
  end

  // Record payload, only meaningful with push_q
  always_ff @(posedge clk_i) begin
    if (sel_trace.pc_v) begin
      rec_q <= rec_d;
    end
  end

  assign rec_o      = rec_q;
  assign rec_push_o = push_q;

endmodule

/* rtl/trace_fifo.sv */
`timescale 1ns/100ps

module trace_fifo #(
  parameter int unsigned LOG_DEPTH = 3
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  snoop_pkg::trace_t    rec_i,
  input  logic                 push_i,
  input  logic                 pop_i,
  output snoop_pkg::trace_t    trace_o,
  output logic                 trace_valid_o,
  output logic [LOG_DEPTH:0]   fill_count_o,
  output logic                 overflow_o
);

  import snoop_pkg::*;

  localparam logic [LOG_DEPTH:0] DEPTH = 1 << LOG_DEPTH;

  trace_t               mem_q [DEPTH];
  logic [LOG_DEPTH-1:0] wr_ptr_q;
  logic [LOG_DEPTH-1:0] rd_ptr_q;
  logic [LOG_DEPTH:0]   count_q;

  logic empty;
  logic full;
  logic do_push;
  logic do_pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == DEPTH);

  // A pop frees a slot in the same cycle, so full never blocks push then
  assign do_pop  = pop_i && !empty;
  assign do_push = push_i && (!full || do_pop);

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  // Head record shown fall-through
  assign trace_o       = mem_q[rd_ptr_q];
  assign trace_valid_o = !empty;
  assign fill_count_o  = count_q;

  // Dropped record
  assign overflow_o = push_i && full && !do_pop;

endmodule

/* rtl/snoop_ctrl.sv */
`timescale 1ns/100ps

module snoop_ctrl #(
  parameter int unsigned LOG_DEPTH = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cfg_we_i,
  input  logic                   cfg_re_i,
  input  snoop_pkg::cfg_addr_t   cfg_addr_i,
  input  snoop_pkg::word_t       cfg_wdata_i,
  input  snoop_pkg::trace_t      rec_i,
  input  logic                   rec_push_i,
  input  logic [LOG_DEPTH:0]     fill_count_i,
  input  logic                   overflow_i,
  output snoop_pkg::word_t       cfg_rdata_o,
  output logic                   cfg_rvalid_o,
  output logic                   core_sel_o,
  output logic                   watermark_irq_o,
  output logic                   trigger_irq_o
);

  import snoop_pkg::*;

  word_t ctrl_q;
  word_t watermark_q;
  word_t trigger_q;
  logic  ovf_q;

  word_t rdata_d;
  word_t rdata_q;
  logic  rvalid_q;
  word_t status;
  word_t count_ext;

  logic  trig_hit;
  logic  trig_irq_q;
  logic  wm_irq_q;

  // --------------------
  // Register writes
  // --------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q      <= '0;
      watermark_q <= '0;
      trigger_q   <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        REG_CTRL:      ctrl_q      <= cfg_wdata_i;
        REG_WATERMARK: watermark_q <= cfg_wdata_i;
        REG_TRIGGER:   trigger_q   <= cfg_wdata_i;
        // Status is read-only
        default: ;
      endcase
    end
  end

  // Sticky overflow, a new drop wins over the clear-on-read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ovf_q <= 1'b0;
    end else if (overflow_i) begin
      ovf_q <= 1'b1;
    end else if (cfg_re_i && (cfg_addr_i == REG_STATUS)) begin
      ovf_q <= 1'b0;
    end
  end

  // --------------------
  // Readback
  // --------------------

  always_comb begin
    status                 = '0;
    status[STATUS_COUNT_W-1:0] = STATUS_COUNT_W'(fill_count_i);
    status[STATUS_OVF_BIT] = ovf_q;
    case (cfg_addr_i)
      REG_CTRL:      rdata_d = ctrl_q;
      REG_WATERMARK: rdata_d = watermark_q;
      REG_TRIGGER:   rdata_d = trigger_q;
      default:       rdata_d = status;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= cfg_re_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_re_i) begin
      rdata_q <= rdata_d;
    end
  end

  // --------------------
  // Interrupts
  // --------------------

  // Target low word against the programmed address
  assign trig_hit = rec_push_i && ctrl_q[CTRL_TRIG_EN_BIT] &&
                    (rec_i.pc_dst_l == trigger_q);

  assign count_ext = word_t'(fill_count_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      trig_irq_q <= 1'b0;
      wm_irq_q   <= 1'b0;
    end else begin
      trig_irq_q <= trig_hit;
      // Zero watermark disables the level
      wm_irq_q   <= (watermark_q != '0) && (count_ext >= watermark_q);
    end
  end

  assign cfg_rdata_o     = rdata_q;
  assign cfg_rvalid_o    = rvalid_q;
  assign core_sel_o      = ctrl_q[CTRL_CORE_SEL_BIT];
  assign watermark_irq_o = wm_irq_q;
  assign trigger_irq_o   = trig_irq_q;

endmodule

/* rtl/cfi_snoop_top.sv */
`timescale 1ns/100ps

module cfi_snoop_top #(
  parameter int unsigned LOG_DEPTH = 3
) (
  input  logic                                               clk_i,
  input  logic                                               rst_n_i,
  // Core trace ports
  input  snoop_pkg::core_trace_t [snoop_pkg::NUM_CORES-1:0]  core_trace_i,
  // Configuration port
  input  logic                                               cfg_we_i,
  input  logic                                               cfg_re_i,
  input  snoop_pkg::cfg_addr_t                               cfg_addr_i,
  input  snoop_pkg::word_t                                   cfg_wdata_i,
  output snoop_pkg::word_t                                   cfg_rdata_o,
  output logic                                               cfg_rvalid_o,
  // Trace read port
  output snoop_pkg::trace_t                                  trace_o,
  output logic                                               trace_valid_o,
  input  logic                                               trace_pop_i,
  // Interrupts
  output logic                                               watermark_irq_o,
  output logic                                               trigger_irq_o
);

  import snoop_pkg::*;

  logic               core_sel;
  trace_t             rec;
  logic               rec_push;
  logic [LOG_DEPTH:0] fill_count;
  logic               overflow;

  // --------------------
  // Input side
  // --------------------

  trace_capture trace_capture_inst (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .core_trace_i ( core_trace_i ),
    .core_sel_i   ( core_sel     ),
    .rec_o        ( rec          ),
    .rec_push_o   ( rec_push     )
  );

  // Record buffer
  trace_fifo #(
    .LOG_DEPTH ( LOG_DEPTH )
  ) trace_fifo_inst (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .rec_i         ( rec           ),
    .push_i        ( rec_push      ),
    .pop_i         ( trace_pop_i   ),
    .trace_o       ( trace_o       ),
    .trace_valid_o ( trace_valid_o ),
    .fill_count_o  ( fill_count    ),
    .overflow_o    ( overflow      )
  );

  // Registers and interrupts
  snoop_ctrl #(
    .LOG_DEPTH ( LOG_DEPTH )
  ) snoop_ctrl_inst (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .cfg_we_i        ( cfg_we_i        ),
    .cfg_re_i        ( cfg_re_i        ),
    .cfg_addr_i      ( cfg_addr_i      ),
    .cfg_wdata_i     ( cfg_wdata_i     ),
    .rec_i           ( rec             ),
    .rec_push_i      ( rec_push        ),
    .fill_count_i    ( fill_count      ),
    .overflow_i      ( overflow        ),
    .cfg_rdata_o     ( cfg_rdata_o     ),
    .cfg_rvalid_o    ( cfg_rvalid_o    ),
    .core_sel_o      ( core_sel        ),
    .watermark_irq_o ( watermark_irq_o ),
    .trigger_irq_o   ( trigger_irq_o   )
  );

endmodule

/* testbench/tb_cfi_snoop.sv */
`timescale 1ns/100ps

module tb_cfi_snoop;

  import snoop_pkg::*;

  localparam int unsigned LOG_DEPTH    = 3;
  localparam int unsigned DEPTH        = 1 << LOG_DEPTH;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned FLOW_CYCLES  = 60;
  localparam int unsigned TRIG_CYCLES  = 40;
  localparam int unsigned DRAIN_MAX    = 4 * DEPTH;
  // Summed test lengths, each drain taken at its worst case
  localparam int unsigned TEST_CYCLES  = RESET_CYCLES + 2 * FLOW_CYCLES + 2 * TRIG_CYCLES +
                                         5 * DRAIN_MAX + 5 * DEPTH + 20;
  localparam int unsigned MAX_CYCLES   = 2 * TEST_CYCLES;

  logic                        clk;
  logic                        rst_n;
  core_trace_t [NUM_CORES-1:0] core_trace;
  logic                        cfg_we;
  logic                        cfg_re;
  cfg_addr_t                   cfg_addr;
  word_t                       cfg_wdata;
  word_t                       cfg_rdata;
  logic                        cfg_rvalid;
  trace_t                      trace_head;
  logic                        trace_valid;
  logic                        trace_pop;
  logic                        watermark_irq;
  logic                        trigger_irq;

  // Reference model state
  trace_t      model_q[$];
  trace_t      pend_rec;
  logic        pend_v;
  logic        sel_m;
  logic        trig_en_m;
  word_t       wm_m;
  word_t       trig_addr_m;
  logic        match_en;
  int unsigned exp_pulses;
  int unsigned seen_pulses;
  int unsigned cycle_count = 0;
  logic [31:0] lfsr;
  string       test_name;

  cfi_snoop_top #(
    .LOG_DEPTH ( LOG_DEPTH )
  ) cfi_snoop_top_inst (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .core_trace_i    ( core_trace    ),
    .cfg_we_i        ( cfg_we        ),
    .cfg_re_i        ( cfg_re        ),
    .cfg_addr_i      ( cfg_addr      ),
    .cfg_wdata_i     ( cfg_wdata     ),
    .cfg_rdata_o     ( cfg_rdata     ),
    .cfg_rvalid_o    ( cfg_rvalid    ),
    .trace_o         ( trace_head    ),
    .trace_valid_o   ( trace_valid   ),
    .trace_pop_i     ( trace_pop     ),
    .watermark_irq_o ( watermark_irq ),
    .trigger_irq_o   ( trigger_irq   )
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
      stop_on_failure();
    end
  end

  // --------------------
  // Random source and model
  // --------------------

  // Taps 32, 22, 2, 1, one step per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  // Zero bit over PC[62:32] for the high word, PC[31:1] over a zero bit for the low
  function automatic trace_t expected_record(input core_trace_t c);
    trace_t t;
    t.priv_lvl = c.priv;
    t.pc_src_h = {1'b0, c.src_pc[62:32]};
    t.pc_src_l = {c.src_pc[31:1], 1'b0};
    t.pc_dst_h = {1'b0, c.dst_pc[62:32]};
    t.pc_dst_l = {c.dst_pc[31:1], 1'b0};
    t.metadata = {28'h0, c.ctr_type};
    t.opcode   = c.instr;
    return t;
  endfunction

  // Mode 0 idle, 1 random valid, 2 always valid
  function automatic core_trace_t random_core(input int mode);
    core_trace_t c;
    logic [63:0] r;
    c.src_pc   = rand_bits(64);
    c.dst_pc   = rand_bits(64);
    c.ctr_type = ctr_type_t'(rand_bits(4));
    c.priv     = priv_t'(rand_bits(2));
    c.instr    = word_t'(rand_bits(32));
    r          = (mode == 1) ? rand_bits(1) : 64'(mode == 2);
    c.pc_v     = r[0];
    if (match_en) begin
      r = rand_bits(1);
      if (r[0]) begin
        c.dst_pc[31:1] = trig_addr_m[31:1];
      end
    end
    return c;
  endfunction

  // --------------------
  // Checks
  // --------------------

  task automatic stop_on_failure();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_trace(input string what, input trace_t exp, input trace_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  // --------------------
  // Cycle driver
  // --------------------

  // One clock edge, model advanced with the inputs the DUT saw at that edge
  task automatic tick();
    logic        trig_exp;
    logic        wm_exp;
    logic        drop;
    core_trace_t sel;
    trig_exp = pend_v && trig_en_m && (pend_rec.pc_dst_l == trig_addr_m);
    wm_exp   = (wm_m != '0) && (model_q.size() >= wm_m);
    sel      = core_trace[sel_m];
    @(posedge clk);
    #1;
    if (trace_pop && model_q.size() != 0) begin
      void'(model_q.pop_front());
    end
    // Full buffer drops the record
    drop = pend_v && (model_q.size() == DEPTH);
    if (pend_v && !drop) begin
      model_q.push_back(pend_rec);
    end
    if (cfg_we && cfg_addr == REG_CTRL) begin
      sel_m     = cfg_wdata[0];
      trig_en_m = cfg_wdata[1];
    end
    if (cfg_we && cfg_addr == REG_WATERMARK) begin
      wm_m = cfg_wdata;
    end
    if (cfg_we && cfg_addr == REG_TRIGGER) begin
      trig_addr_m = cfg_wdata;
    end
    pend_v   = sel.pc_v;
    pend_rec = expected_record(sel);
    if (trig_exp) begin
      exp_pulses++;
    end
    if (trigger_irq === 1'b1) begin
      seen_pulses++;
    end
    check_bit("trigger irq", trig_exp, trigger_irq);
    check_bit("watermark irq", wm_exp, watermark_irq);
    check_bit("read valid", cfg_re, cfg_rvalid);
  endtask

  task automatic drive_cycle(input logic do_pop, input int mode);
    check_bit("trace valid", model_q.size() != 0, trace_valid);
    if (do_pop && trace_valid) begin
      check_trace("popped record", model_q[0], trace_head);
      trace_pop = 1'b1;
    end
    core_trace[0] = random_core(mode);
    core_trace[1] = random_core(mode);
    tick();
    trace_pop = 1'b0;
  endtask

  task automatic write_reg(input cfg_addr_t addr, input word_t data);
    core_trace[0].pc_v = 1'b0;
    core_trace[1].pc_v = 1'b0;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_we = 1'b0;
  endtask

  task automatic read_reg(input cfg_addr_t addr, input word_t exp);
    core_trace[0].pc_v = 1'b0;
    core_trace[1].pc_v = 1'b0;
    cfg_re   = 1'b1;
    cfg_addr = addr;
    tick();
    cfg_re = 1'b0;
    check_word("readback", exp, cfg_rdata);
  endtask

  task automatic drain();
    int unsigned n;
    n = 0;
    while ((model_q.size() != 0 || pend_v) && n < DRAIN_MAX) begin
      drive_cycle(1'b1, 0);
      n++;
    end
    check_bit("empty after drain", 1'b0, trace_valid);
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    core_trace  = '0;
    cfg_we      = 1'b0;
    cfg_re      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    trace_pop   = 1'b0;
    lfsr        = 32'h23f0;
    pend_v      = 1'b0;
    pend_rec    = '0;
    sel_m       = 1'b0;
    trig_en_m   = 1'b0;
    wm_m        = '0;
    trig_addr_m = '0;
    match_en    = 1'b0;
    exp_pulses  = 0;
    seen_pulses = 0;
    test_name   = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit("trace valid", 1'b0, trace_valid);
    check_bit("read valid", 1'b0, cfg_rvalid);
    check_bit("watermark irq", 1'b0, watermark_irq);
    check_bit("trigger irq", 1'b0, trigger_irq);

    test_name = "flow";
    repeat (FLOW_CYCLES) drive_cycle(1'b1, 1);
    drain();

    test_name = "core_select";
    write_reg(REG_CTRL, 32'h1);
    read_reg(REG_CTRL, 32'h1);
    repeat (FLOW_CYCLES) drive_cycle(1'b1, 1);
    drain();

    // Overrun the buffer, then let the last pushes land
    test_name = "overflow";
    repeat (DEPTH + 4) drive_cycle(1'b0, 2);
    repeat (2) drive_cycle(1'b0, 0);
    read_reg(REG_STATUS, word_t'(32'h0001_0000 | DEPTH));
    read_reg(REG_STATUS, word_t'(DEPTH));
    drain();

    test_name = "watermark";
    write_reg(REG_WATERMARK, word_t'(rand_bits(3)) + 32'd1);
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle(1'b0, 2);
      repeat (3) drive_cycle(1'b0, 0);
      check_bit("watermark level", model_q.size() >= wm_m, watermark_irq);
    end
    drain();
    write_reg(REG_WATERMARK, '0);

    test_name = "trigger";
    write_reg(REG_TRIGGER, word_t'(rand_bits(32)) & 32'hffff_fffe);
    write_reg(REG_CTRL, 32'h3);
    match_en = 1'b1;
    repeat (TRIG_CYCLES) drive_cycle(1'b1, 1);
    repeat (3) drive_cycle(1'b1, 0);
    check_word("pulse count", word_t'(exp_pulses), word_t'(seen_pulses));
    if (exp_pulses == 0) begin
      $display("The trigger test sent no record that matched the trigger address");
      stop_on_failure();
    end
    write_reg(REG_CTRL, 32'h1);
    seen_pulses = 0;
    repeat (TRIG_CYCLES / 2) drive_cycle(1'b1, 1);
    drain();
    check_word("pulses while disabled", '0, word_t'(seen_pulses));
    match_en = 1'b0;

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* all.f */
rtl/snoop_pkg.sv
rtl/trace_capture.sv
rtl/trace_fifo.sv
rtl/snoop_ctrl.sv
rtl/cfi_snoop_top.sv
testbench/tb_cfi_snoop.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_cfi_snoop
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF -- '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
